/* mmc3_addr_map.sv */
`timescale 1ns/1ps

module mmc3_addr_map (
    input  logic [15:0]                     cpu_addr,
    input  logic                            cpu_rw,
    input  logic [13:0]                     ppu_addr,
    input  logic                            ppu_rd,
    input  logic                            ppu_wr,
    input  logic                            chr_ram,
    input  logic                            prg_mode,
    input  logic                            chr_mode,
    input  logic [mmc3_pkg::CHR_BANK_W-1:0] chr_bank0,
    input  logic [mmc3_pkg::CHR_BANK_W-1:0] chr_bank1,
    input  logic [mmc3_pkg::CHR_BANK_W-1:0] chr_bank2,
    input  logic [mmc3_pkg::CHR_BANK_W-1:0] chr_bank3,
    input  logic [mmc3_pkg::CHR_BANK_W-1:0] chr_bank4,
    input  logic [mmc3_pkg::CHR_BANK_W-1:0] chr_bank5,
    input  logic [mmc3_pkg::PRG_BANK_W-1:0] prg_bank0,
    input  logic [mmc3_pkg::PRG_BANK_W-1:0] prg_bank1,
    input  logic                            mirroring,
    input  logic                            prg_ram_en,
    input  logic                            prg_ram_wp,
    output logic [mmc3_pkg::PRG_ADDR_W-1:0] prg_addr,
    output logic                            prg_oe,
    output logic                            prg_we,
    output logic                            wram_ce,
    output logic [mmc3_pkg::CHR_ADDR_W-1:0] chr_addr,
    output logic                            chr_oe,
    output logic                            chr_we,
    output logic                            ciram_ce,
    output logic                            ciram_a10
);
    logic [mmc3_pkg::PRG_BANK_W-1:0] prg_sel;
    logic [mmc3_pkg::CHR_BANK_W-1:0] chr_sel;
    logic                            chr_2k_half;

    assign wram_ce  = (cpu_addr[15:13] == 3'b011) && prg_ram_en;  // $6000-$7FFF
    assign prg_oe   = cpu_rw && (cpu_addr[15] || wram_ce);
    assign prg_we   = !cpu_rw && wram_ce && !prg_ram_wp;
    assign prg_addr = wram_ce ? {{mmc3_pkg::PRG_BANK_W{1'b0}}, cpu_addr[12:0]}
                              : {prg_sel, cpu_addr[12:0]};

    always_comb begin
        case (cpu_addr[14:13])
            2'b00:   prg_sel = prg_mode ? mmc3_pkg::PRG_BANK_SECOND_LAST : prg_bank0;
            2'b01:   prg_sel = prg_bank1;
            2'b10:   prg_sel = prg_mode ? prg_bank0 : mmc3_pkg::PRG_BANK_SECOND_LAST;
            default: prg_sel = mmc3_pkg::PRG_BANK_LAST;
        endcase
    end

    // chr_mode moves the 2 KB pair to the upper pattern table
    assign chr_2k_half = ppu_addr[12] == chr_mode;

    always_comb begin
        if (chr_2k_half) begin
            if (ppu_addr[11]) chr_sel = {chr_bank1[7:1], ppu_addr[10]};
            else chr_sel = {chr_bank0[7:1], ppu_addr[10]};
        end else begin
            case (ppu_addr[11:10])
                2'b00:   chr_sel = chr_bank2;
                2'b01:   chr_sel = chr_bank3;
                2'b10:   chr_sel = chr_bank4;
                default: chr_sel = chr_bank5;
            endcase
        end
    end

    assign chr_addr  = {chr_sel, ppu_addr[9:0]};
    assign chr_oe    = !ppu_rd;
    assign chr_we    = chr_ram && !ppu_wr;  // Only CHR RAM boards take writes
    assign ciram_ce  = !ppu_addr[13];
    assign ciram_a10 = mirroring ? ppu_addr[11] : ppu_addr[10];

endmodule

/* mmc3_mapper.f */
mmc3_pkg.sv
mmc3_regs.sv
mmc3_scanline_irq.sv
mmc3_addr_map.sv
mmc3_mapper.sv
mmc3_tb.sv

/* mmc3_mapper.sv */
`timescale 1ns/1ps

module mmc3_mapper (
    input  logic                            m2,
    input  logic                            rst_n,
    input  logic [15:0]                     cpu_addr,
    input  logic                            cpu_rw,
    input  logic [7:0]                      cpu_data_in,
    input  logic [13:0]                     ppu_addr,
    input  logic                            ppu_rd,
    input  logic                            ppu_wr,
    input  logic                            chr_ram,
    input  logic                            sst_enable,
    input  logic                            sst_we,
    input  logic [mmc3_pkg::SST_ADDR_W-1:0] sst_addr,
    input  logic [7:0]                      sst_data_in,
    output logic [7:0]                      sst_data_out,
    output logic [mmc3_pkg::PRG_ADDR_W-1:0] prg_addr,
    output logic                            prg_oe,
    output logic                            prg_we,
    output logic                            wram_ce,
    output logic [mmc3_pkg::CHR_ADDR_W-1:0] chr_addr,
    output logic                            chr_oe,
    output logic                            chr_we,
    output logic                            ciram_ce,
    output logic                            ciram_a10,
    output logic                            irq_n
);
    logic prg_mode, chr_mode, mirroring, prg_ram_en, prg_ram_wp;
    logic [mmc3_pkg::CHR_BANK_W-1:0] chr_bank0, chr_bank1, chr_bank2;
    logic [mmc3_pkg::CHR_BANK_W-1:0] chr_bank3, chr_bank4, chr_bank5;
    logic [mmc3_pkg::PRG_BANK_W-1:0] prg_bank0, prg_bank1;
    logic irq_latch_wr, irq_reload_set, irq_disable, irq_enable_set;
    logic sst_irq_wr, freeze, a12_state;
    logic [7:0] irq_wdata, irq_latch, irq_count;
    logic [2:0] irq_flags;
    logic [mmc3_pkg::SST_ADDR_W-1:0] sst_irq_slot;

    mmc3_regs u_regs (
        .m2, .rst_n, .cpu_addr, .cpu_rw, .cpu_data_in,
        .sst_enable, .sst_we, .sst_addr, .sst_data_in,
        .irq_latch, .irq_count, .irq_flags, .a12_state,
        .prg_mode, .chr_mode, .chr_bank0, .chr_bank1, .chr_bank2,
        .chr_bank3, .chr_bank4, .chr_bank5, .prg_bank0, .prg_bank1,
        .mirroring, .prg_ram_en, .prg_ram_wp,
        .irq_latch_wr, .irq_reload_set, .irq_disable, .irq_enable_set,
        .irq_wdata, .sst_irq_wr, .sst_irq_slot, .freeze, .sst_data_out
    );

    mmc3_scanline_irq u_irq (
        .m2, .rst_n,
        .ppu_a12 (ppu_addr[12]),  // Pattern table select drives the count
        .freeze, .irq_latch_wr, .irq_reload_set, .irq_disable, .irq_enable_set,
        .irq_wdata, .sst_irq_wr, .sst_irq_slot,
        .irq_latch, .irq_count, .irq_flags, .a12_state, .irq_n
    );

    mmc3_addr_map u_map (
        .cpu_addr, .cpu_rw, .ppu_addr, .ppu_rd, .ppu_wr, .chr_ram,
        .prg_mode, .chr_mode, .chr_bank0, .chr_bank1, .chr_bank2,
        .chr_bank3, .chr_bank4, .chr_bank5, .prg_bank0, .prg_bank1,
        .mirroring, .prg_ram_en, .prg_ram_wp,
        .prg_addr, .prg_oe, .prg_we, .wram_ce, .chr_addr, .chr_oe, .chr_we,
        .ciram_ce, .ciram_a10
    );

endmodule

/* mmc3_pkg.sv */
package mmc3_pkg;

    localparam int PRG_BANK_W = 6;
    localparam int CHR_BANK_W = 8;
    localparam int PRG_ADDR_W = PRG_BANK_W + 13;  // 8 KB PRG windows
    localparam int CHR_ADDR_W = CHR_BANK_W + 10;  // 1 KB CHR windows

    localparam logic [PRG_BANK_W-1:0] PRG_BANK_SECOND_LAST = 6'h3E;
    localparam logic [PRG_BANK_W-1:0] PRG_BANK_LAST        = 6'h3F;

    localparam int A12_LOW_CYCLES = 3;  // Low samples needed to re-arm

    localparam int SST_ADDR_W = 4;

    localparam logic [SST_ADDR_W-1:0] SST_CTRL      = 4'd0;
    localparam logic [SST_ADDR_W-1:0] SST_CHR0      = 4'd1;
    localparam logic [SST_ADDR_W-1:0] SST_CHR1      = 4'd2;
    localparam logic [SST_ADDR_W-1:0] SST_CHR2      = 4'd3;
    localparam logic [SST_ADDR_W-1:0] SST_CHR3      = 4'd4;
    localparam logic [SST_ADDR_W-1:0] SST_CHR4      = 4'd5;
    localparam logic [SST_ADDR_W-1:0] SST_CHR5      = 4'd6;
    localparam logic [SST_ADDR_W-1:0] SST_PRG0      = 4'd7;
    localparam logic [SST_ADDR_W-1:0] SST_PRG1      = 4'd8;
    localparam logic [SST_ADDR_W-1:0] SST_RAM       = 4'd9;
    localparam logic [SST_ADDR_W-1:0] SST_IRQ_LATCH = 4'd10;
    localparam logic [SST_ADDR_W-1:0] SST_IRQ_COUNT = 4'd11;
    localparam logic [SST_ADDR_W-1:0] SST_IRQ_FLAGS = 4'd12;
    localparam logic [SST_ADDR_W-1:0] SST_A12       = 4'd13;

    localparam logic [7:0] SST_EMPTY = 8'hFF;  // Unused slot readback

endpackage

/* mmc3_regs.sv */
`timescale 1ns/1ps

module mmc3_regs (
    input  logic                                m2,
    input  logic                                rst_n,
    input  logic [15:0]                         cpu_addr,
    input  logic                                cpu_rw,
    input  logic [7:0]                          cpu_data_in,
    input  logic                                sst_enable,
    input  logic                                sst_we,
    input  logic [mmc3_pkg::SST_ADDR_W-1:0]     sst_addr,
    input  logic [7:0]                          sst_data_in,
    input  logic [7:0]                          irq_latch,
    input  logic [7:0]                          irq_count,
    input  logic [2:0]                          irq_flags,
    input  logic                                a12_state,
    output logic                                prg_mode,
    output logic                                chr_mode,
    output logic [mmc3_pkg::CHR_BANK_W-1:0]     chr_bank0,
    output logic [mmc3_pkg::CHR_BANK_W-1:0]     chr_bank1,
    output logic [mmc3_pkg::CHR_BANK_W-1:0]     chr_bank2,
    output logic [mmc3_pkg::CHR_BANK_W-1:0]     chr_bank3,
    output logic [mmc3_pkg::CHR_BANK_W-1:0]     chr_bank4,
    output logic [mmc3_pkg::CHR_BANK_W-1:0]     chr_bank5,
    output logic [mmc3_pkg::PRG_BANK_W-1:0]     prg_bank0,
    output logic [mmc3_pkg::PRG_BANK_W-1:0]     prg_bank1,
    output logic                                mirroring,
    output logic                                prg_ram_en,
    output logic                                prg_ram_wp,
    output logic                                irq_latch_wr,
    output logic                                irq_reload_set,
    output logic                                irq_disable,
    output logic                                irq_enable_set,
    output logic [7:0]                          irq_wdata,
    output logic                                sst_irq_wr,
    output logic [mmc3_pkg::SST_ADDR_W-1:0]     sst_irq_slot,
    output logic                                freeze,
    output logic [7:0]                          sst_data_out
);
    logic [2:0] bank_sel;
    logic [mmc3_pkg::CHR_BANK_W-1:0] chr_bank [6];
    logic       cpu_wr;
    logic [2:0] reg_sel;

    assign cpu_wr  = cpu_addr[15] && !cpu_rw && !sst_enable;
    assign reg_sel = {cpu_addr[14:13], cpu_addr[0]};

    assign irq_latch_wr   = cpu_wr && (reg_sel == 3'b10_0);  // $C000
    assign irq_reload_set = cpu_wr && (reg_sel == 3'b10_1);  // $C001
    assign irq_disable    = cpu_wr && (reg_sel == 3'b11_0);  // $E000
    assign irq_enable_set = cpu_wr && (reg_sel == 3'b11_1);  // $E001

    assign freeze       = sst_enable;
    assign irq_wdata    = sst_enable ? sst_data_in : cpu_data_in;
    assign sst_irq_slot = sst_addr;
    assign sst_irq_wr   = sst_enable && sst_we && (sst_addr >= mmc3_pkg::SST_IRQ_LATCH)
                          && (sst_addr <= mmc3_pkg::SST_A12);

    assign chr_bank0 = chr_bank[0];
    assign chr_bank1 = chr_bank[1];
    assign chr_bank2 = chr_bank[2];
    assign chr_bank3 = chr_bank[3];
    assign chr_bank4 = chr_bank[4];
    assign chr_bank5 = chr_bank[5];

    always_ff @(posedge m2) begin
        if (!rst_n) begin
            bank_sel   <= '0;
            prg_mode   <= 1'b0;
            chr_mode   <= 1'b0;
            chr_bank   <= '{default: '0};
            prg_bank0  <= '0;
            prg_bank1  <= '0;
            mirroring  <= 1'b0;
            prg_ram_en <= 1'b0;
            prg_ram_wp <= 1'b0;
        end else if (sst_enable) begin
            if (sst_we) begin
                case (sst_addr)
                    mmc3_pkg::SST_CTRL: begin
                        {chr_mode, prg_mode} <= sst_data_in[7:6];
                        bank_sel             <= sst_data_in[2:0];
                    end
                    mmc3_pkg::SST_CHR0: chr_bank[0] <= sst_data_in;
                    mmc3_pkg::SST_CHR1: chr_bank[1] <= sst_data_in;
                    mmc3_pkg::SST_CHR2: chr_bank[2] <= sst_data_in;
                    mmc3_pkg::SST_CHR3: chr_bank[3] <= sst_data_in;
                    mmc3_pkg::SST_CHR4: chr_bank[4] <= sst_data_in;
                    mmc3_pkg::SST_CHR5: chr_bank[5] <= sst_data_in;
                    mmc3_pkg::SST_PRG0: prg_bank0 <= sst_data_in[5:0];
                    mmc3_pkg::SST_PRG1: prg_bank1 <= sst_data_in[5:0];
                    mmc3_pkg::SST_RAM: begin
                        {prg_ram_en, prg_ram_wp} <= sst_data_in[7:6];
                        mirroring                <= sst_data_in[0];
                    end
                    default: ;  // IRQ slots live in the counter block
                endcase
            end
        end else if (cpu_wr) begin
            case (reg_sel)
                3'b00_0: begin  // $8000
                    bank_sel <= cpu_data_in[2:0];
                    prg_mode <= cpu_data_in[6];
                    chr_mode <= cpu_data_in[7];
                end
                3'b00_1: begin  // $8001
                    if (bank_sel[2:1] != 2'b11) begin
                        chr_bank[bank_sel] <= cpu_data_in;
                    end else if (!bank_sel[0]) begin
                        prg_bank0 <= cpu_data_in[5:0];
                    end else begin
                        prg_bank1 <= cpu_data_in[5:0];
                    end
                end
                3'b01_0: mirroring <= cpu_data_in[0];  // $A000
                3'b01_1: begin  // $A001
                    prg_ram_en <= cpu_data_in[7];
                    prg_ram_wp <= cpu_data_in[6];
                end
                default: ;  // IRQ strobes decoded above
            endcase
        end
    end

    always_comb begin
        case (sst_addr)
            mmc3_pkg::SST_CTRL:      sst_data_out = {chr_mode, prg_mode, 3'b0, bank_sel};
            mmc3_pkg::SST_CHR0:      sst_data_out = chr_bank[0];
            mmc3_pkg::SST_CHR1:      sst_data_out = chr_bank[1];
            mmc3_pkg::SST_CHR2:      sst_data_out = chr_bank[2];
            mmc3_pkg::SST_CHR3:      sst_data_out = chr_bank[3];
            mmc3_pkg::SST_CHR4:      sst_data_out = chr_bank[4];
            mmc3_pkg::SST_CHR5:      sst_data_out = chr_bank[5];
            mmc3_pkg::SST_PRG0:      sst_data_out = {2'b0, prg_bank0};
            mmc3_pkg::SST_PRG1:      sst_data_out = {2'b0, prg_bank1};
            mmc3_pkg::SST_RAM:       sst_data_out = {prg_ram_en, prg_ram_wp, 5'b0, mirroring};
            mmc3_pkg::SST_IRQ_LATCH: sst_data_out = irq_latch;
            mmc3_pkg::SST_IRQ_COUNT: sst_data_out = irq_count;
            mmc3_pkg::SST_IRQ_FLAGS: sst_data_out = {5'b0, irq_flags};
            mmc3_pkg::SST_A12:       sst_data_out = {7'b0, a12_state};
            default:                 sst_data_out = mmc3_pkg::SST_EMPTY;
        endcase
    end

endmodule

/* mmc3_scanline_irq.sv */
`timescale 1ns/1ps

module mmc3_scanline_irq (
    input  logic                            m2,
    input  logic                            rst_n,
    input  logic                            ppu_a12,
    input  logic                            freeze,
    input  logic                            irq_latch_wr,
    input  logic                            irq_reload_set,
    input  logic                            irq_disable,
    input  logic                            irq_enable_set,
    input  logic [7:0]                      irq_wdata,
    input  logic                            sst_irq_wr,
    input  logic [mmc3_pkg::SST_ADDR_W-1:0] sst_irq_slot,
    output logic [7:0]                      irq_latch,
    output logic [7:0]                      irq_count,
    output logic [2:0]                      irq_flags,
    output logic                            a12_state,
    output logic                            irq_n
);
    // Two past samples plus the live pin give the low run
    logic [mmc3_pkg::A12_LOW_CYCLES-2:0] a12_hist;
    logic irq_enable;
    logic irq_pending;
    logic irq_reload;
    logic a12_rise;

    assign a12_rise  = ppu_a12 && !a12_state;  // a12_state set means disarmed
    assign irq_flags = {irq_enable, irq_pending, irq_reload};
    assign irq_n     = !irq_pending;

    always_ff @(posedge m2) begin
        if (!rst_n) begin
            a12_hist    <= '0;
            a12_state   <= 1'b0;
            irq_latch   <= '0;
            irq_count   <= '0;
            irq_enable  <= 1'b0;
            irq_pending <= 1'b0;
            irq_reload  <= 1'b0;
        end else if (freeze) begin
            if (sst_irq_wr) begin
                case (sst_irq_slot)
                    mmc3_pkg::SST_IRQ_LATCH: irq_latch <= irq_wdata;
                    mmc3_pkg::SST_IRQ_COUNT: irq_count <= irq_wdata;
                    mmc3_pkg::SST_IRQ_FLAGS: begin
                        {irq_enable, irq_pending, irq_reload} <= irq_wdata[2:0];
                    end
                    mmc3_pkg::SST_A12:       a12_state <= irq_wdata[0];
                    default: ;
                endcase
            end
        end else begin
            a12_hist <= {a12_hist[mmc3_pkg::A12_LOW_CYCLES-3:0], ppu_a12};

            if (ppu_a12) begin
                a12_state <= 1'b1;
            end else if (a12_hist == '0) begin
                a12_state <= 1'b0;  // Re-armed after three lows
            end

            if (a12_rise) begin
                if (irq_count == 8'd0 || irq_reload) begin
                    irq_count  <= irq_latch;
                    irq_reload <= 1'b0;
                    if (irq_latch == 8'd0 && irq_enable) irq_pending <= 1'b1;
                end else begin
                    irq_count <= irq_count - 8'd1;
                    if (irq_count == 8'd1 && irq_enable) irq_pending <= 1'b1;
                end
            end

            // CPU writes come last so they win over the counter
            if (irq_latch_wr) irq_latch <= irq_wdata;
            if (irq_reload_set) irq_reload <= 1'b1;
            if (irq_disable) begin
                irq_enable  <= 1'b0;
                irq_pending <= 1'b0;
            end
            if (irq_enable_set) irq_enable <= 1'b1;
        end
    end

    // A pending flag with enable off can only come from a restore
    a_irq_needs_enable: assert property (@(posedge m2) disable iff (!rst_n)
        (!irq_n && !irq_enable) |-> ($past(sst_irq_wr) || $past(!irq_n && !irq_enable)));

endmodule

/* mmc3_tb.sv */
`timescale 1ns/1ps

module mmc3_tb;

    localparam int MAX_CYCLES = 3000;  // Several times the full sequence

    logic m2;
    logic rst_n;
    logic [15:0] cpu_addr;
    logic cpu_rw;
    logic [7:0] cpu_data_in;
    logic [13:0] ppu_addr;
    logic ppu_rd, ppu_wr, chr_ram;
    logic sst_enable, sst_we;
    logic [mmc3_pkg::SST_ADDR_W-1:0] sst_addr;
    logic [7:0] sst_data_in, sst_data_out;
    logic [mmc3_pkg::PRG_ADDR_W-1:0] prg_addr;
    logic prg_oe, prg_we, wram_ce;
    logic [mmc3_pkg::CHR_ADDR_W-1:0] chr_addr;
    logic chr_oe, chr_we, ciram_ce, ciram_a10, irq_n;

    // Reference model of the mapper registers
    logic [2:0] m_bank_sel;
    logic m_prg_mode, m_chr_mode, m_mirr, m_ram_en, m_ram_wp;
    logic [7:0] m_chr [6];
    logic [5:0] m_prg [2];
    logic [7:0] m_latch, m_count;
    logic m_en, m_pend, m_reload;
    logic [1:0] m_low_run;  // Low A12 samples in a row, saturates at 3

    logic [1:0] win;
    logic [5:0] win_bank;
    logic [2:0] region;
    logic [7:0] region_bank;
    logic exp_wram;
    logic [2:0] exp_cpu_pins;
    logic [3:0] exp_ppu_pins;
    logic [mmc3_pkg::PRG_ADDR_W-1:0] exp_prg_addr;
    logic [mmc3_pkg::CHR_ADDR_W-1:0] exp_chr_addr;
    logic [7:0] exp_sst;

    string test_name;
    int value_errs;
    int check_errs;
    int cycles = 0;
    integer seed;
    logic [31:0] rnd;
    logic [7:0] latch_n;

    mmc3_mapper dut0 (.*);

    always #5 m2 = ~m2;

    always @(posedge m2) begin
        if (!rst_n) begin
            m_bank_sel <= '0;
            {m_prg_mode, m_chr_mode, m_mirr, m_ram_en, m_ram_wp} <= '0;
            m_chr <= '{default: '0};
            m_prg <= '{default: '0};
            {m_latch, m_count} <= '0;
            {m_en, m_pend, m_reload} <= '0;
            m_low_run <= 2'd3;  // Filter comes out of reset armed
        end else if (sst_enable) begin
            if (sst_we) begin
                case (sst_addr)
                    4'd0: begin
                        {m_chr_mode, m_prg_mode} <= sst_data_in[7:6];
                        m_bank_sel <= sst_data_in[2:0];
                    end
                    4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6: m_chr[sst_addr[2:0] - 3'd1] <= sst_data_in;
                    4'd7, 4'd8: m_prg[~sst_addr[0]] <= sst_data_in[5:0];
                    4'd9: begin
                        {m_ram_en, m_ram_wp} <= sst_data_in[7:6];
                        m_mirr <= sst_data_in[0];
                    end
                    4'd10: m_latch <= sst_data_in;
                    4'd11: m_count <= sst_data_in;
                    4'd12: {m_en, m_pend, m_reload} <= sst_data_in[2:0];
                    4'd13: m_low_run <= sst_data_in[0] ? 2'd0 : 2'd3;
                    default: ;
                endcase
            end
        end else begin
            if (ppu_addr[12]) begin
                m_low_run <= 2'd0;
                if (m_low_run == 2'd3) begin  // Counted rise
                    if (m_count == 8'd0 || m_reload) begin
                        m_count <= m_latch;
                        m_reload <= 1'b0;
                        if (m_latch == 8'd0 && m_en) m_pend <= 1'b1;
                    end else begin
                        m_count <= m_count - 8'd1;
                        if (m_count == 8'd1 && m_en) m_pend <= 1'b1;
                    end
                end
            end else if (m_low_run != 2'd3) begin
                m_low_run <= m_low_run + 2'd1;
            end
            if (cpu_addr[15] && !cpu_rw) begin
                case ({cpu_addr[14:13], cpu_addr[0]})
                    3'd0: begin
                        m_bank_sel <= cpu_data_in[2:0];
                        m_prg_mode <= cpu_data_in[6];
                        m_chr_mode <= cpu_data_in[7];
                    end
                    3'd1: begin
                        if (m_bank_sel < 3'd6) m_chr[m_bank_sel] <= cpu_data_in;
                        else m_prg[m_bank_sel[0]] <= cpu_data_in[5:0];
                    end
                    3'd2: m_mirr <= cpu_data_in[0];
                    3'd3: {m_ram_en, m_ram_wp} <= cpu_data_in[7:6];
                    3'd4: m_latch <= cpu_data_in;
                    3'd5: m_reload <= 1'b1;
                    3'd6: {m_en, m_pend} <= 2'b00;
                    default: m_en <= 1'b1;
                endcase
            end
        end
    end

    always_comb begin
        // Mode 1 trades the two even windows, $8000 and $C000
        win = (m_prg_mode && !cpu_addr[13]) ? {~cpu_addr[14], 1'b0} : cpu_addr[14:13];
        case (win)
            2'd0: win_bank = m_prg[0];
            2'd1: win_bank = m_prg[1];
            2'd2: win_bank = 6'd62;
            default: win_bank = 6'd63;
        endcase
        exp_wram = cpu_addr >= 16'h6000 && cpu_addr < 16'h8000 && m_ram_en;
        exp_cpu_pins = {exp_wram, cpu_rw && (cpu_addr[15] || exp_wram),
                        !cpu_rw && exp_wram && !m_ram_wp};
        exp_prg_addr = exp_wram ? {6'd0, cpu_addr[12:0]} : {win_bank, cpu_addr[12:0]};
        region = {ppu_addr[12] ^ m_chr_mode, ppu_addr[11:10]};  // Half swap
        if (region[2]) region_bank = m_chr[region[1:0] + 3'd2];
        else region_bank = {m_chr[{2'b00, region[1]}][7:1], ppu_addr[10]};
        exp_chr_addr = {region_bank, ppu_addr[9:0]};
        exp_ppu_pins = {!ppu_rd, chr_ram && !ppu_wr, !ppu_addr[13],
                        m_mirr ? ppu_addr[11] : ppu_addr[10]};
        case (sst_addr)
            4'd0: exp_sst = {m_chr_mode, m_prg_mode, 3'b000, m_bank_sel};
            4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6: exp_sst = m_chr[sst_addr[2:0] - 3'd1];
            4'd7, 4'd8: exp_sst = {2'b00, m_prg[~sst_addr[0]]};
            4'd9: exp_sst = {m_ram_en, m_ram_wp, 5'b00000, m_mirr};
            4'd10: exp_sst = m_latch;
            4'd11: exp_sst = m_count;
            4'd12: exp_sst = {5'b00000, m_en, m_pend, m_reload};
            4'd13: exp_sst = {7'b0000000, m_low_run != 2'd3};
            default: exp_sst = 8'hFF;
        endcase
    end

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        value_errs++;
        $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, sig, exp_v, act_v);
    endtask

    a_prg_addr: assert property (@(posedge m2) disable iff (!rst_n) prg_addr == exp_prg_addr)
        else report_mismatch("prg_addr", 32'($sampled(exp_prg_addr)), 32'($sampled(prg_addr)));
    a_cpu_pins: assert property (@(posedge m2) disable iff (!rst_n)
        {wram_ce, prg_oe, prg_we} == exp_cpu_pins)
        else report_mismatch("wram_ce/prg_oe/prg_we", 32'($sampled(exp_cpu_pins)),
                             32'($sampled({wram_ce, prg_oe, prg_we})));
    a_chr_addr: assert property (@(posedge m2) disable iff (!rst_n) chr_addr == exp_chr_addr)
        else report_mismatch("chr_addr", 32'($sampled(exp_chr_addr)), 32'($sampled(chr_addr)));
    a_ppu_pins: assert property (@(posedge m2) disable iff (!rst_n)
        {chr_oe, chr_we, ciram_ce, ciram_a10} == exp_ppu_pins)
        else report_mismatch("chr_oe/chr_we/ciram", 32'($sampled(exp_ppu_pins)),
                             32'($sampled({chr_oe, chr_we, ciram_ce, ciram_a10})));
    a_irq_n: assert property (@(posedge m2) disable iff (!rst_n) irq_n == !m_pend)
        else report_mismatch("irq_n", 32'($sampled(!m_pend)), 32'($sampled(irq_n)));
    a_sst_data: assert property (@(posedge m2) disable iff (!rst_n) sst_data_out == exp_sst)
        else report_mismatch("sst_data_out", 32'($sampled(exp_sst)), 32'($sampled(sst_data_out)));

    task automatic step();
        @(posedge m2);
        #1;
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        cpu_addr = addr;
        cpu_rw = 1'b0;
        cpu_data_in = data;
        step();
        cpu_rw = 1'b1;
        cpu_addr = 16'h0000;
    endtask

    task automatic sst_write(input logic [3:0] slot, input logic [7:0] data);
        sst_addr = slot;
        sst_data_in = data;
        sst_we = 1'b1;
        step();
        sst_we = 1'b0;
    endtask

    task automatic a12_pulse(input int lows);
        ppu_addr[12] = 1'b0;
        repeat (lows) step();
        ppu_addr[12] = 1'b1;  // One high sample
        step();
        ppu_addr[12] = 1'b0;
    endtask

    task automatic expect_irq_n(input logic exp_v);
        assert (irq_n == exp_v) else begin
            check_errs++;
            $display("[FAIL] %s irq_n: expected %b, actual %b", test_name, exp_v, irq_n);
        end
    endtask

    always @(posedge m2) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        seed = 32'hd792;
        value_errs = 0;
        check_errs = 0;
        test_name = "reset_state";
        m2 = 1'b0;
        rst_n = 1'b0;
        cpu_addr = 16'h0000;
        cpu_rw = 1'b1;
        cpu_data_in = 8'h00;
        ppu_addr = 14'h0000;
        ppu_rd = 1'b1;
        ppu_wr = 1'b1;
        chr_ram = 1'b0;
        sst_enable = 1'b0;
        sst_we = 1'b0;
        sst_addr = 4'd0;
        sst_data_in = 8'h00;
        repeat (3) @(posedge m2);
        #1;
        rst_n = 1'b1;
        cpu_addr = 16'h6000;  // Work RAM write with RAM still disabled
        cpu_rw = 1'b0;
        for (int s = 0; s < 16; s++) begin
            sst_addr = s[3:0];
            step();
        end
        cpu_rw = 1'b1;
        cpu_addr = 16'h0000;
        expect_irq_n(1'b1);

        test_name = "prg_map";
        for (int mode = 0; mode < 2; mode++) begin
            for (int b = 6; b < 8; b++) begin
                rnd = $random(seed);
                cpu_write(16'h8000, {1'b0, mode[0], 3'b000, b[2:0]});
                cpu_write(16'h8001, rnd[7:0]);
            end
            for (int w = 0; w < 4; w++) begin
                rnd = $random(seed);
                cpu_addr = {1'b1, w[1:0], rnd[12:0]};
                step();
            end
        end

        test_name = "chr_map";
        for (int b = 0; b < 6; b++) begin
            rnd = $random(seed);
            cpu_write(16'h8000, {5'b00000, b[2:0]});
            cpu_write(16'h8001, rnd[7:0]);
        end
        for (int mode = 0; mode < 2; mode++) begin
            cpu_write(16'h8000, {mode[0], 7'b0000000});
            for (int r = 0; r < 8; r++) begin
                rnd = $random(seed);
                ppu_addr = {rnd[13], r[2:0], rnd[9:0]};
                chr_ram = rnd[16];
                ppu_wr = rnd[17];
                ppu_rd = rnd[18];
                step();
            end
        end
        ppu_addr = 14'h0000;

        test_name = "wram_mirroring";
        for (int c = 0; c < 4; c++) begin
            cpu_write(16'hA001, {c[1:0], 6'b000000});
            rnd = $random(seed);
            cpu_addr = {3'b011, rnd[12:0]};
            cpu_rw = 1'b0;
            step();
            cpu_rw = 1'b1;
            step();
        end
        for (int m = 0; m < 2; m++) begin
            cpu_write(16'hA000, {7'b0000000, m[0]});
            for (int k = 0; k < 4; k++) begin
                rnd = $random(seed);
                ppu_addr = {2'b10, rnd[11:0]};
                step();
            end
        end
        ppu_addr = 14'h0000;
        cpu_addr = 16'h0000;

        test_name = "scanline_irq";
        sst_addr = mmc3_pkg::SST_IRQ_COUNT;  // Counter stays visible to the model check
        rnd = $random(seed);
        latch_n = {5'b00000, rnd[2:0]} + 8'd2;
        cpu_write(16'hC000, latch_n);
        cpu_write(16'hC001, 8'h00);
        cpu_write(16'hE001, 8'h00);
        repeat (latch_n) begin
            a12_pulse(3);
            expect_irq_n(1'b1);
        end
        a12_pulse(3);
        expect_irq_n(1'b0);
        a12_pulse(1);
        a12_pulse(2);
        a12_pulse(1);
        cpu_write(16'hE000, 8'h00);
        expect_irq_n(1'b1);
        cpu_write(16'hC000, 8'h00);
        cpu_write(16'hC001, 8'h00);
        cpu_write(16'hE001, 8'h00);
        repeat (3) begin
            a12_pulse(3);
            expect_irq_n(1'b0);
            cpu_write(16'hE000, 8'h00);
            cpu_write(16'hE001, 8'h00);
        end
        cpu_write(16'hE000, 8'h00);

        test_name = "save_state";
        sst_enable = 1'b1;
        for (int s = 0; s < 14; s++) begin
            rnd = $random(seed);
            sst_write(s[3:0], rnd[7:0]);
        end
        sst_addr = mmc3_pkg::SST_PRG1;
        cpu_write(16'h8001, 8'h5A);
        cpu_write(16'hA001, 8'h00);
        a12_pulse(3);
        for (int s = 0; s < 16; s++) begin
            sst_addr = s[3:0];
            step();
        end
        for (int r = 0; r < 8; r++) begin
            cpu_addr = {1'b1, r[1:0], 13'h0ABC};
            ppu_addr = {1'b0, r[2:0], 10'h155};
            step();
        end
        sst_write(mmc3_pkg::SST_A12, 8'h00);
        sst_enable = 1'b0;
        cpu_addr = 16'h0000;
        ppu_addr = 14'h0000;
        repeat (4) step();

        $display("Summary: %0d model mismatches, %0d directed check failures",
                 value_errs, check_errs);
        if (value_errs + check_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator and run; pass only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module mmc3_tb \
    -f mmc3_mapper.f -o mmc3_sim || exit 1
out=$(./obj_dir/mmc3_sim)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && exit 0 || exit 1
